// File: common/ins_q_if.sv
// fetch/queue/exec link; plain levels only, redirect is a single-cycle pulse
`timescale 1ns/1ps

interface ins_q_if;

	// fetch side, word returned by instruction memory
	logic                 push;
	tcore_pkg::ins_t      push_ins;
	// high with one free slot or less
	logic                 nearly_full;

	// exec side, head valid while empty is low
	logic                 pop;
	tcore_pkg::ins_t      head_ins;
	logic                 empty;

	// jump flush and pc reload
	logic                 redirect;
	tcore_pkg::iaddr_t    redirect_addr;
	// sticky stop, blocks further fetch
	logic                 halted;

	// producer
	modport fetch (
		output push, push_ins,
		input  nearly_full, redirect, redirect_addr, halted
	);

	// buffer
	modport queue (
		input  push, push_ins, pop, redirect,
		output head_ins, empty, nearly_full
	);

	// consumer
	modport exec (
		output pop, redirect, redirect_addr, halted,
		input  head_ins, empty
	);

endinterface

// File: common/tcore_pkg.sv
// shared widths and types for tcore; opcode field fixed at bits 15:12, unknown codes run as nop

package tcore_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	// data path and register width
	parameter int DAT_W = 16;
	// one instruction per memory word
	parameter int INS_W = 16;
	// 1k words of instruction memory
	parameter int IMEM_AW = 10;
	// direct data addresses come from bits 7:0
	parameter int DMEM_AW = 8;
	// eight general registers
	parameter int REG_AW = 3;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------
	typedef logic [DAT_W-1:0]   dat_t;
	typedef logic [INS_W-1:0]   ins_t;
	typedef logic [IMEM_AW-1:0] iaddr_t;
	typedef logic [DMEM_AW-1:0] daddr_t;
	typedef logic [REG_AW-1:0]  reg_idx_t;

	// --------------------------------------------------
	// opcodes
	// --------------------------------------------------
	// register fields at 11:9, 8:6 and 5:3
	// ldi, ld and st carry an 8-bit value in 7:0
	// jmp target sits in 9:0
	typedef enum logic [3:0] {
		// no operation
		op_nop  = 4'd0,
		// ra <= zero-extended imm8
		op_ldi  = 4'd1,
		// ra <= rb + rc
		op_add  = 4'd2,
		// ra <= rb - rc
		op_sub  = 4'd3,
		// ra <= low half of rb * rc
		op_mul  = 4'd4,
		// ra <= dmem[addr8], two cycles
		op_ld   = 4'd5,
		// dmem[addr8] <= ra
		op_st   = 4'd6,
		// pc <= target, queue flushed
		op_jmp  = 4'd7,
		// sticky stop until reset
		op_halt = 4'd15
	} opcode_e;

endpackage

// File: dv/tb_tcore.sv
// directed tests on behavioral 1-cycle memories; unused imem words hold halt, first error ends the run
`timescale 1ns/1ps

module tb_tcore;

	// six tests, 2000 cycles each, 20 ns clock
	localparam int WDOG_NS = 6 * 2000 * 20;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               t_cs;
	tcore_pkg::ins_t    ins_mem_dat;
	logic               ins_mem_en_b;
	tcore_pkg::iaddr_t  ins_mem_addr;
	logic               dat_mem_en_b;
	logic               dat_mem_rw;
	tcore_pkg::daddr_t  dat_mem_addr;
	tcore_pkg::dat_t    dat_mem_wdat;
	tcore_pkg::dat_t    dat_mem_rdat;
	logic               halt;

	tcore_pkg::ins_t    imem [1024];
	tcore_pkg::dat_t    dmem [256];
	// per-address write flags, cleared at each program load
	logic               wr_seen [256];
	int                 wr_cnt;
	// next free imem slot for the assembler
	int                 asm_pc;

	always #10 clk = ~clk;

	tcore_top #(
		.IQ_DEPTH (4)
	) u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.t_cs         (t_cs),
		.ins_mem_dat  (ins_mem_dat),
		.ins_mem_en_b (ins_mem_en_b),
		.ins_mem_addr (ins_mem_addr),
		.dat_mem_en_b (dat_mem_en_b),
		.dat_mem_rw   (dat_mem_rw),
		.dat_mem_addr (dat_mem_addr),
		.dat_mem_wdat (dat_mem_wdat),
		.dat_mem_rdat (dat_mem_rdat),
		.halt         (halt)
	);

	// --------------------------------------------------
	// memory models, data valid the cycle after enable
	// --------------------------------------------------
	always @(posedge clk) begin
		if (!ins_mem_en_b) begin
			ins_mem_dat <= imem[ins_mem_addr];
		end
		if (!dat_mem_en_b && dat_mem_rw) begin
			dat_mem_rdat <= dmem[dat_mem_addr];
		end else if (!dat_mem_en_b) begin
			dmem[dat_mem_addr]    <= dat_mem_wdat;
			wr_seen[dat_mem_addr] <= 1'b1;
			wr_cnt                <= wr_cnt + 1;
			$display("%0t dmem write [%02h] = %04h", $time, dat_mem_addr, dat_mem_wdat);
		end
	end

	// --------------------------------------------------
	// assembler
	// --------------------------------------------------
	// register form, fields at 11:9, 8:6, 5:3
	function automatic tcore_pkg::ins_t rrr(logic [3:0] op, logic [2:0] a, logic [2:0] b,
			logic [2:0] c);
		return {op, a, b, c, 3'b000};
	endfunction

	// ldi, ld, st: register plus 8-bit value
	function automatic tcore_pkg::ins_t rim(logic [3:0] op, logic [2:0] a, logic [7:0] v);
		return {op, a, 1'b0, v};
	endfunction

	task automatic emit(tcore_pkg::ins_t ins);
		imem[asm_pc] = ins;
		asm_pc++;
	endtask

	// --------------------------------------------------
	// run control and checks
	// --------------------------------------------------
	task automatic abort_run(string why);
		$display("TESTBENCH FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic expect_eq(string name, logic [15:0] exp, logic [15:0] got);
		assert (got === exp) else begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
			abort_run("value mismatch");
		end
	endtask

	task automatic expect_mem(logic [7:0] addr, logic [15:0] exp);
		expect_eq($sformatf("dmem[%02h]", addr), exp, dmem[addr]);
	endtask

	task automatic expect_untouched(logic [7:0] addr);
		assert (!wr_seen[addr]) else begin
			$display("t=%0t a store reached address %02h, which must stay unwritten", $time, addr);
			abort_run("unexpected data memory write");
		end
	endtask

	// holds reset and refills both memories, program goes in afterwards
	task automatic begin_prog(logic cs);
		@(posedge clk);
		rst_n <= 1'b0;
		t_cs  <= cs;
		// halt opcode, low bits carry the word address
		for (int i = 0; i < 1024; i++) begin
			imem[i] = {4'hf, 2'b00, 10'(i)};
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i]    = {8'(i) ^ 8'h5a, 8'(i)};
			wr_seen[i] = 1'b0;
		end
		wr_cnt = 0;
		asm_pc = 0;
	endtask

	task automatic release_reset();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_halt();
		@(negedge clk);
		while (halt !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic arith_store();
		logic [7:0] a;
		logic [7:0] b;
		a = 8'($urandom);
		b = 8'($urandom);
		begin_prog(1'b1);
		emit(rim(tcore_pkg::op_ldi, 3'd1, a));
		emit(rim(tcore_pkg::op_ldi, 3'd2, b));
		emit(rrr(tcore_pkg::op_add, 3'd3, 3'd1, 3'd2));
		emit(rrr(tcore_pkg::op_sub, 3'd4, 3'd1, 3'd2));
		emit(rrr(tcore_pkg::op_sub, 3'd5, 3'd2, 3'd1));
		emit(rim(tcore_pkg::op_st, 3'd3, 8'h10));
		emit(rim(tcore_pkg::op_st, 3'd4, 8'h11));
		emit(rim(tcore_pkg::op_st, 3'd5, 8'h12));
		release_reset();
		wait_halt();
		expect_mem(8'h10, 16'(a) + 16'(b));
		// differences wrap modulo 2^16
		expect_mem(8'h11, 16'(a) - 16'(b));
		expect_mem(8'h12, 16'(b) - 16'(a));
	endtask

	task automatic mul_low_half();
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  z;
		logic [7:0]  w;
		logic [15:0] opa;
		logic [15:0] opb;
		x = 8'($urandom);
		y = 8'($urandom);
		z = 8'($urandom);
		w = 8'($urandom);
		opa = (16'(x) << 4) + 16'(y);
		opb = 16'(z) + 16'(w);
		begin_prog(1'b1);
		emit(rim(tcore_pkg::op_ldi, 3'd1, x));
		// four doublings give x * 16
		repeat (4) emit(rrr(tcore_pkg::op_add, 3'd1, 3'd1, 3'd1));
		emit(rim(tcore_pkg::op_ldi, 3'd2, y));
		emit(rrr(tcore_pkg::op_add, 3'd1, 3'd1, 3'd2));
		emit(rim(tcore_pkg::op_ldi, 3'd3, z));
		emit(rim(tcore_pkg::op_ldi, 3'd4, w));
		emit(rrr(tcore_pkg::op_add, 3'd3, 3'd3, 3'd4));
		emit(rrr(tcore_pkg::op_mul, 3'd5, 3'd1, 3'd3));
		emit(rim(tcore_pkg::op_st, 3'd5, 8'h20));
		release_reset();
		wait_halt();
		expect_mem(8'h20, opa * opb);
	endtask

	task automatic load_add();
		logic [15:0] p0;
		logic [15:0] p1;
		p0 = 16'($urandom);
		p1 = 16'($urandom);
		begin_prog(1'b1);
		dmem[8'h40] = p0;
		dmem[8'h41] = p1;
		emit(rim(tcore_pkg::op_ld, 3'd1, 8'h40));
		emit(rim(tcore_pkg::op_ld, 3'd2, 8'h41));
		emit(rrr(tcore_pkg::op_add, 3'd3, 3'd1, 3'd2));
		emit(rrr(tcore_pkg::op_sub, 3'd4, 3'd2, 3'd1));
		emit(rim(tcore_pkg::op_st, 3'd3, 8'h42));
		emit(rim(tcore_pkg::op_st, 3'd4, 8'h43));
		emit(rim(tcore_pkg::op_st, 3'd1, 8'h44));
		release_reset();
		wait_halt();
		expect_mem(8'h42, p0 + p1);
		expect_mem(8'h43, p1 - p0);
		expect_mem(8'h44, p0);
	endtask

	task automatic jump_skip();
		logic [7:0] v;
		v = 8'($urandom);
		begin_prog(1'b1);
		emit(rim(tcore_pkg::op_ldi, 3'd1, v));
		emit({4'(tcore_pkg::op_jmp), 2'b00, 10'd8});
		// words 2..7 are skipped stores
		for (int i = 0; i < 6; i++) begin
			emit(rim(tcore_pkg::op_st, 3'd1, 8'h50 + 8'(i)));
		end
		emit(rim(tcore_pkg::op_st, 3'd1, 8'h60));
		release_reset();
		wait_halt();
		for (int i = 0; i < 6; i++) begin
			expect_untouched(8'h50 + 8'(i));
		end
		expect_mem(8'h60, 16'(v));
	endtask

	task automatic halt_sticky();
		logic [7:0] v;
		int         snap;
		v = 8'($urandom);
		begin_prog(1'b1);
		emit(rim(tcore_pkg::op_ldi, 3'd1, v));
		emit(rim(tcore_pkg::op_st, 3'd1, 8'h70));
		emit(16'hf000);
		emit(rim(tcore_pkg::op_st, 3'd1, 8'h71));
		release_reset();
		wait_halt();
		snap = wr_cnt;
		repeat (50) begin
			@(negedge clk);
			expect_eq("halt", 16'd1, 16'(halt));
			expect_eq("ins_mem_en_b", 16'd1, 16'(ins_mem_en_b));
		end
		expect_eq("data write count", 16'(snap), 16'(wr_cnt));
		expect_mem(8'h70, 16'(v));
		expect_untouched(8'h71);
	endtask

	task automatic cs_gate();
		logic [7:0] a;
		logic [7:0] b;
		a = 8'($urandom);
		b = 8'($urandom);
		begin_prog(1'b0);
		// r0 is still zero, a store sits at the head first
		emit(rim(tcore_pkg::op_st, 3'd0, 8'h31));
		emit(rim(tcore_pkg::op_ldi, 3'd1, a));
		emit(rim(tcore_pkg::op_ldi, 3'd2, b));
		emit(rrr(tcore_pkg::op_mul, 3'd3, 3'd1, 3'd2));
		emit(rim(tcore_pkg::op_st, 3'd3, 8'h30));
		release_reset();
		// deselected, nothing may touch either memory
		repeat (40) begin
			@(negedge clk);
			expect_eq("ins_mem_en_b", 16'd1, 16'(ins_mem_en_b));
			expect_eq("dat_mem_en_b", 16'd1, 16'(dat_mem_en_b));
		end
		// one fetch, then deselect with the store waiting at the head
		@(posedge clk);
		t_cs <= 1'b1;
		@(posedge clk);
		t_cs <= 1'b0;
		repeat (20) begin
			@(negedge clk);
			expect_eq("dat_mem_en_b", 16'd1, 16'(dat_mem_en_b));
		end
		@(posedge clk);
		t_cs <= 1'b1;
		wait_halt();
		expect_mem(8'h31, 16'd0);
		expect_mem(8'h30, 16'(a) * 16'(b));
	endtask

	// --------------------------------------------------
	// main sequence and watchdog
	// --------------------------------------------------
	initial begin
		rst_n        = 1'b0;
		t_cs         = 1'b0;
		ins_mem_dat  = '0;
		dat_mem_rdat = '0;
		void'($urandom(32'h488c2a6c));
		arith_store();
		mul_low_half();
		load_add();
		jump_skip();
		halt_sticky();
		cs_gate();
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin
		#(WDOG_NS);
		abort_run("watchdog expired before all tests finished");
	end

endmodule

// File: rtl/exec/gprf.sv
// 8 x 16 register file, reads are combinational so a write shows up the next cycle
`timescale 1ns/1ps

module gprf (
	input  logic                 clk,
	input  logic                 rst_n,
	input  tcore_pkg::reg_idx_t  rd_a,
	output tcore_pkg::dat_t      rd_a_dat,
	input  tcore_pkg::reg_idx_t  rd_b,
	output tcore_pkg::dat_t      rd_b_dat,
	input  logic                 wr_en,
	input  tcore_pkg::reg_idx_t  wr_idx,
	input  tcore_pkg::dat_t      wr_dat
);

	localparam int NUM_REGS = 2 ** tcore_pkg::REG_AW;

	// r0 is an ordinary register
	tcore_pkg::dat_t regs [NUM_REGS];

	// --------------------------------------------------
	// read ports
	// --------------------------------------------------
	assign rd_a_dat = regs[rd_a];
	assign rd_b_dat = regs[rd_b];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// programs may rely on zeroed registers
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_dat;
		end
	end

endmodule

// File: rtl/exec/ins_exec.sv
// single-issue exec, ld takes 2 cycles and blocks the queue; stalls while empty, deselected or halted
`timescale 1ns/1ps

module ins_exec (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               t_cs,
	ins_q_if.exec              q,
	output logic               dat_mem_en_b,
	output logic               dat_mem_rw,
	output tcore_pkg::daddr_t  dat_mem_addr,
	output tcore_pkg::dat_t    dat_mem_wdat,
	input  tcore_pkg::dat_t    dat_mem_rdat,
	output logic               halt
);

	typedef enum logic {
		exec_idle,
		exec_ld_wait
	} exec_state_e;

	exec_state_e          state;
	logic                 halted_q;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	tcore_pkg::opcode_e   op;
	tcore_pkg::reg_idx_t  fld_a;
	tcore_pkg::reg_idx_t  fld_b;
	tcore_pkg::reg_idx_t  fld_c;
	logic [7:0]           imm8;

	// register file hookup
	tcore_pkg::reg_idx_t  rd_a;
	tcore_pkg::dat_t      rd_a_dat;
	tcore_pkg::dat_t      rd_b_dat;
	logic                 wr_en;
	tcore_pkg::reg_idx_t  wr_idx;
	tcore_pkg::dat_t      wr_dat;

	// alu result and its write request
	tcore_pkg::dat_t      alu_res;
	logic                 alu_wr;

	// ld destination held over the wait cycle
	tcore_pkg::reg_idx_t  ld_dst;

	logic                 exec_go;
	logic                 is_ld;
	logic                 is_st;

	assign op    = tcore_pkg::opcode_e'(q.head_ins[15:12]);
	assign fld_a = q.head_ins[11:9];
	assign fld_b = q.head_ins[8:6];
	assign fld_c = q.head_ins[5:3];
	assign imm8  = q.head_ins[7:0];

	// head executes this cycle
	assign exec_go = t_cs && !q.empty && !halted_q && (state == exec_idle);
	// every opcode leaves the queue in its first cycle
	assign q.pop   = exec_go;

	assign is_ld = exec_go && (op == tcore_pkg::op_ld);
	assign is_st = exec_go && (op == tcore_pkg::op_st);

	// --------------------------------------------------
	// register reads
	// --------------------------------------------------
	// st sends ra out as write data, alu ops read rb
	assign rd_a = (op == tcore_pkg::op_st) ? fld_a : fld_b;

	// --------------------------------------------------
	// alu
	// --------------------------------------------------
	always_comb begin
		alu_wr  = 1'b0;
		alu_res = '0;
		case (op)
			tcore_pkg::op_ldi: begin
				alu_wr  = 1'b1;
				// zero extend
				alu_res = {{(tcore_pkg::DAT_W - 8){1'b0}}, imm8};
			end
			tcore_pkg::op_add: begin
				alu_wr  = 1'b1;
				alu_res = rd_a_dat + rd_b_dat;
			end
			tcore_pkg::op_sub: begin
				alu_wr  = 1'b1;
				alu_res = rd_a_dat - rd_b_dat;
			end
			tcore_pkg::op_mul: begin
				alu_wr  = 1'b1;
				// keeps low 16 bits of product
				alu_res = rd_a_dat * rd_b_dat;
			end
			// ld, st, jmp, halt and unused codes write nothing here
			default: begin
				alu_wr  = 1'b0;
				alu_res = '0;
			end
		endcase
	end

	// write port shared by alu and ld return
	assign wr_en  = (exec_go && alu_wr) || (state == exec_ld_wait);
	assign wr_idx = (state == exec_ld_wait) ? ld_dst : fld_a;
	assign wr_dat = (state == exec_ld_wait) ? dat_mem_rdat : alu_res;

	// --------------------------------------------------
	// data memory
	// --------------------------------------------------
	// rw: 1 read, 0 write
	assign dat_mem_en_b = !(is_ld || is_st);
	assign dat_mem_rw   = !is_st;
	assign dat_mem_addr = q.head_ins[tcore_pkg::DMEM_AW-1:0];
	assign dat_mem_wdat = rd_a_dat;

	// jump pulse, queue and fetch act on the next edge
	assign q.redirect      = exec_go && (op == tcore_pkg::op_jmp);
	assign q.redirect_addr = q.head_ins[tcore_pkg::IMEM_AW-1:0];

	assign q.halted = halted_q;
	assign halt     = halted_q;

	// --------------------------------------------------
	// fsm and halt flag
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= exec_idle;
			halted_q <= 1'b0;
		end else begin
			case (state)
				exec_idle:    state <= is_ld ? exec_ld_wait : exec_idle;
				// read data lands this cycle
				exec_ld_wait: state <= exec_idle;
				default:      state <= exec_idle;
			endcase
			// sticky until reset
			if (exec_go && (op == tcore_pkg::op_halt)) begin
				halted_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (is_ld) begin
			ld_dst <= fld_a;
		end
	end

	gprf u_gprf (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_a     (rd_a),
		.rd_a_dat (rd_a_dat),
		.rd_b     (fld_c),
		.rd_b_dat (rd_b_dat),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_dat   (wr_dat)
	);

endmodule

// File: rtl/fetch/pc_fetch.sv
// one read per cycle into a 1-cycle sync imem; relies on nearly_full leaving a slot for the read in flight
`timescale 1ns/1ps

module pc_fetch (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               t_cs,
	ins_q_if.fetch             q,
	input  tcore_pkg::ins_t    ins_mem_dat,
	output logic               ins_mem_en_b,
	output tcore_pkg::iaddr_t  ins_mem_addr
);

	// --------------------------------------------------
	// state
	// --------------------------------------------------
	// next address to read
	tcore_pkg::iaddr_t pc;
	// a read was issued last cycle, data on ins_mem_dat now
	logic              rd_pend;
	// read request this cycle
	logic              rd_issue;

	// --------------------------------------------------
	// read request
	// --------------------------------------------------
	// no new read while the queue is close to full,
	// while stopped or deselected
	// a redirect cycle issues nothing, the old pc is stale
	assign rd_issue = t_cs && !q.halted && !q.nearly_full && !q.redirect;

	// active-low enable straight from the request
	assign ins_mem_en_b = !rd_issue;
	assign ins_mem_addr = pc;

	// --------------------------------------------------
	// push of returned word
	// --------------------------------------------------
	// memory latency is one cycle, so push follows the read
	assign q.push     = rd_pend;
	assign q.push_ins = ins_mem_dat;

	// --------------------------------------------------
	// pc and pending bit
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= '0;
			rd_pend <= 1'b0;
		end else if (q.redirect) begin
			// jump target, any word in flight is dropped
			pc      <= q.redirect_addr;
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= rd_issue;
			// advance only on an accepted read
			if (rd_issue) begin
				pc <= pc + 1'b1;
			end
		end
	end

endmodule

// File: rtl/ins_queue.sv
// fwft instruction queue, IQ_DEPTH >= 2; redirect clear beats a same-cycle push
`timescale 1ns/1ps

module ins_queue #(
	parameter int IQ_DEPTH = 4
) (
	input  logic   clk,
	input  logic   rst_n,
	ins_q_if.queue q
);

	localparam int PTR_W = $clog2(IQ_DEPTH);
	localparam int CNT_W = $clog2(IQ_DEPTH + 1);

	// storage, payload only
	tcore_pkg::ins_t  mem [IQ_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// words held
	logic [CNT_W-1:0] count;

	logic             full;
	logic             wr_ok;
	logic             rd_ok;

	// --------------------------------------------------
	// status
	// --------------------------------------------------
	assign full          = (count == CNT_W'(IQ_DEPTH));
	assign q.empty       = (count == '0);
	// one slot or less left, covers the fetch already in flight
	assign q.nearly_full = (count >= CNT_W'(IQ_DEPTH - 1));
	// head always on the read pointer
	assign q.head_ins    = mem[rd_ptr];

	// full guard, fetch should never hit it
	assign wr_ok = q.push && !full;
	assign rd_ok = q.pop && !q.empty;

	// write side, no reset on the array
	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= q.push_ins;
		end
	end

	// --------------------------------------------------
	// pointers and count
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (q.redirect) begin
			// flush on jump
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// wrap by hand, depth need not be a power of two
			if (wr_ok) begin
				wr_ptr <= (wr_ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= (rd_ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: rtl/tcore_top.sv
// tcore core without memories; both mems must be sync with 1-cycle read latency, enables active low
`timescale 1ns/1ps

module tcore_top #(
	// instruction queue depth, 2 or more
	parameter int IQ_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	// chip select, low freezes fetch and execute
	input  logic               t_cs,

	// instruction memory
	input  tcore_pkg::ins_t    ins_mem_dat,
	output logic               ins_mem_en_b,
	output tcore_pkg::iaddr_t  ins_mem_addr,

	// data memory, rw 1 read 0 write
	output logic               dat_mem_en_b,
	output logic               dat_mem_rw,
	output tcore_pkg::daddr_t  dat_mem_addr,
	output tcore_pkg::dat_t    dat_mem_wdat,
	input  tcore_pkg::dat_t    dat_mem_rdat,

	// sticky stop
	output logic               halt
);

	// --------------------------------------------------
	// fetch -> queue -> exec link
	// --------------------------------------------------
	ins_q_if iq ();

	pc_fetch u_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.t_cs         (t_cs),
		.q            (iq),
		.ins_mem_dat  (ins_mem_dat),
		.ins_mem_en_b (ins_mem_en_b),
		.ins_mem_addr (ins_mem_addr)
	);

	ins_queue #(
		.IQ_DEPTH (IQ_DEPTH)
	) u_queue (
		.clk   (clk),
		.rst_n (rst_n),
		.q     (iq)
	);

	// decode, alu and register file
	ins_exec u_exec (
		.clk          (clk),
		.rst_n        (rst_n),
		.t_cs         (t_cs),
		.q            (iq),
		.dat_mem_en_b (dat_mem_en_b),
		.dat_mem_rw   (dat_mem_rw),
		.dat_mem_addr (dat_mem_addr),
		.dat_mem_wdat (dat_mem_wdat),
		.dat_mem_rdat (dat_mem_rdat),
		.halt         (halt)
	);

endmodule

// File: tb.f
common/tcore_pkg.sv
common/ins_q_if.sv
rtl/fetch/pc_fetch.sv
rtl/ins_queue.sv
rtl/exec/gprf.sv
rtl/exec/ins_exec.sv
rtl/tcore_top.sv
dv/tb_tcore.sv
